// File: common/ex_pkg.sv
package ex_pkg;

    typedef enum logic [5:0] {
        ADD, SUB, SLT, SLTU, AND, OR, NOR, XOR, SLL, SRL, SRA, LU12I, PCADDU12I,
        DIVW, MODW, DIVWU, MODWU,
        BEQ, BNE, BLT, BGE, BLTU, BGEU, B, BL, JIRL,
        LDB, LDBU, LDH, LDHU, LDW, STB, STH, STW,
        NOP
    } alu_op_t;

    // source of write-back data
    typedef enum logic [2:0] {
        REGULAR, DIV, BRANCH, MEM, NONE
    } alu_sel_t;

    // instruction word, one view per immediate layout
    typedef union packed {
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] si12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri12;
        struct packed {
            logic [7:0]  opcode;
            logic [13:0] si14;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri14;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri16;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } i26;
    } inst_u;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        inst_u       inst;
        alu_op_t     aluop;
        alu_sel_t    alusel;
        logic [31:0] src1;
        logic [31:0] src2;
        logic        pre_taken;
        logic [31:0] pre_target;
        logic [4:0]  rd;
        logic        rd_we;
    } ex_in_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        rd_we;
        logic [31:0] wdata;
        logic [31:0] mem_addr;
        logic        ale;
    } ex_out_t;

    typedef struct packed {
        logic        valid;
        logic        we;
        logic        uncached;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } dmem_req_t;

    typedef struct packed {
        logic        is_branch;
        logic        taken;
        logic [31:0] target;
        logic        flush;
    } branch_upd_t;

endpackage

// File: design/regular_alu.sv
`timescale 1ns/1ps

module regular_alu (
    input  ex_pkg::alu_op_t op_i,
    input  logic [31:0]     a_i,
    input  logic [31:0]     b_i,
    input  logic [31:0]     pc_i,
    output logic [31:0]     res_o
);
    import ex_pkg::*;

    logic [4:0]  shamt;
    logic [31:0] sum;
    logic [31:0] diff;

    assign shamt = b_i[4:0];
    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;

    always_comb begin
        case (op_i)
            ADD: begin
                res_o = sum;
            end
            SUB: begin
                res_o = diff;
            end
            SLT: begin
                res_o = {31'b0, $signed(a_i) < $signed(b_i)};
            end
            SLTU: begin
                res_o = {31'b0, a_i < b_i};
            end
            AND: begin
                res_o = a_i & b_i;
            end
            OR: begin
                res_o = a_i | b_i;
            end
            NOR: begin
                res_o = ~(a_i | b_i);
            end
            XOR: begin
                res_o = a_i ^ b_i;
            end
            SLL: begin
                res_o = a_i << shamt;
            end
            SRL: begin
                res_o = a_i >> shamt;
            end
            SRA: begin
                res_o = $unsigned($signed(a_i) >>> shamt);
            end
            // immediate comes in already shifted up by 12
            LU12I: begin
                res_o = b_i;
            end
            PCADDU12I: begin
                res_o = pc_i + b_i;
            end
            default: begin
                res_o = 32'b0;
            end
        endcase
    end

endmodule

// File: divider/div_alu.sv
`timescale 1ns/1ps

module div_alu (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        start_i,
    input  logic        signed_i,
    input  logic [31:0] dividend_i,
    input  logic [31:0] divisor_i,
    output logic        busy_o,
    output logic        done_o,
    output logic [31:0] quotient_o,
    output logic [31:0] remainder_o
);
    logic        busy_q;
    logic        done_q;
    logic [4:0]  cnt_q;
    logic [31:0] rem_q;
    logic [31:0] quo_q;
    logic [31:0] dsr_q;
    logic        q_neg_q;
    logic        r_neg_q;

    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic [32:0] trial;
    logic [31:0] rem_nxt;
    logic [31:0] quo_nxt;

    assign a_mag = (signed_i && dividend_i[31]) ? -dividend_i : dividend_i;
    assign b_mag = (signed_i && divisor_i[31]) ? -divisor_i : divisor_i;

    // one restoring step per cycle
    assign trial = {rem_q, quo_q[31]} - {1'b0, dsr_q};

    always_comb begin
        if (!trial[32]) begin
            rem_nxt = trial[31:0];
            quo_nxt = {quo_q[30:0], 1'b1};
        end else begin
            rem_nxt = {rem_q[30:0], quo_q[31]};
            quo_nxt = {quo_q[30:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= 5'd0;
        end else begin
            done_q <= 1'b0;
            if (start_i && !busy_q) begin
                busy_q <= 1'b1;
                cnt_q  <= 5'd0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 5'd1;
                if (cnt_q == 5'd31) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i && !busy_q) begin
            rem_q <= 32'b0;
            quo_q <= a_mag;
            dsr_q <= b_mag;
            // zero divisor keeps the all-ones quotient unsigned
            q_neg_q <= signed_i && (dividend_i[31] ^ divisor_i[31]) && (divisor_i != 32'b0);
            r_neg_q <= signed_i && dividend_i[31];
        end else if (busy_q) begin
            rem_q <= rem_nxt;
            quo_q <= quo_nxt;
            if (cnt_q == 5'd31) begin
                quotient_o  <= q_neg_q ? -quo_nxt : quo_nxt;
                remainder_o <= r_neg_q ? -rem_nxt : rem_nxt;
            end
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;

endmodule

// File: design/branch_alu.sv
`timescale 1ns/1ps

module branch_alu (
    input  ex_pkg::alu_op_t     op_i,
    input  logic [31:0]         pc_i,
    input  ex_pkg::inst_u       inst_i,
    input  logic [31:0]         a_i,
    input  logic [31:0]         b_i,
    input  logic                pre_taken_i,
    input  logic [31:0]         pre_target_i,
    output ex_pkg::branch_upd_t upd_o,
    output logic [31:0]         link_o
);
    import ex_pkg::*;

    logic [25:0] offs26;
    logic [31:0] imm16;
    logic [31:0] imm26;
    logic        is_branch;
    logic        taken;
    logic [31:0] target;

    assign offs26 = {inst_i.i26.offs_hi, inst_i.i26.offs_lo};
    assign imm16  = {{14{inst_i.ri16.offs16[15]}}, inst_i.ri16.offs16, 2'b00};
    assign imm26  = {{4{offs26[25]}}, offs26, 2'b00};

    always_comb begin
        is_branch = 1'b1;
        target    = pc_i + imm16;
        case (op_i)
            BEQ:  taken = (a_i == b_i);
            BNE:  taken = (a_i != b_i);
            BLT:  taken = ($signed(a_i) < $signed(b_i));
            BGE:  taken = ($signed(a_i) >= $signed(b_i));
            BLTU: taken = (a_i < b_i);
            BGEU: taken = (a_i >= b_i);
            B, BL: begin
                taken  = 1'b1;
                target = pc_i + imm26;
            end
            // register-relative jump
            JIRL: begin
                taken  = 1'b1;
                target = a_i + imm16;
            end
            default: begin
                is_branch = 1'b0;
                taken     = 1'b0;
            end
        endcase
    end

    assign link_o          = pc_i + 32'd4;
    assign upd_o.is_branch = is_branch;
    assign upd_o.taken     = taken;
    assign upd_o.target    = target;
    assign upd_o.flush     = is_branch &&
                             ((taken != pre_taken_i) || (taken && (target != pre_target_i)));

endmodule

// File: design/lsu_agen.sv
`timescale 1ns/1ps

module lsu_agen #(
    parameter logic [15:0] UNCACHE_HI = 16'hbfaf
) (
    input  ex_pkg::ex_in_t    in_i,
    output ex_pkg::dmem_req_t req_o,
    output logic              ale_o
);
    import ex_pkg::*;

    logic [31:0] si12_ext;
    logic [31:0] addr;
    logic        is_mem;
    logic        we;
    logic        misaligned;
    logic [31:0] wdata;
    logic [3:0]  wstrb;

    assign si12_ext = {{20{in_i.inst.ri12.si12[11]}}, in_i.inst.ri12.si12};

    always_comb begin
        is_mem     = 1'b1;
        we         = 1'b0;
        addr       = in_i.src1 + in_i.src2;
        misaligned = 1'b0;
        wdata      = 32'b0;
        wstrb      = 4'b1111;
        case (in_i.aluop)
            LDB, LDBU: begin
            end
            LDH, LDHU: begin
                misaligned = addr[0];
            end
            LDW: begin
                misaligned = (addr[1:0] != 2'b00);
            end
            STB: begin
                we    = 1'b1;
                addr  = in_i.src1 + si12_ext;
                wdata = {24'b0, in_i.src2[7:0]} << {addr[1:0], 3'b000};
                wstrb = 4'b0001 << addr[1:0];
            end
            STH: begin
                we         = 1'b1;
                addr       = in_i.src1 + si12_ext;
                misaligned = addr[0];
                wdata      = {16'b0, in_i.src2[15:0]} << {addr[1], 4'b0000};
                wstrb      = 4'b0011 << {addr[1], 1'b0};
            end
            STW: begin
                we         = 1'b1;
                addr       = in_i.src1 + si12_ext;
                misaligned = (addr[1:0] != 2'b00);
                wdata      = in_i.src2;
            end
            default: begin
                is_mem = 1'b0;
                addr   = 32'b0;
            end
        endcase
    end

    assign ale_o          = in_i.valid && is_mem && misaligned;
    assign req_o.valid    = in_i.valid && is_mem && !misaligned;
    assign req_o.we       = we;
    // uncached window only matters for a real request
    assign req_o.uncached = req_o.valid && (addr[31:16] == UNCACHE_HI);
    assign req_o.addr     = addr;
    assign req_o.wdata    = wdata;
    assign req_o.wstrb    = wstrb;

endmodule

// File: design/ex_stage.sv
`timescale 1ns/1ps

module ex_stage #(
    parameter logic [15:0] UNCACHE_HI = 16'hbfaf
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  ex_pkg::ex_in_t      ex_i,
    input  logic                addr_ok_i,
    output ex_pkg::ex_out_t     ex_o,
    output ex_pkg::dmem_req_t   dmem_o,
    output ex_pkg::branch_upd_t bru_o,
    output logic                pause_o
);
    import ex_pkg::*;

    logic [31:0] alu_res;
    logic        is_div;
    logic        is_quot;
    logic        div_start;
    logic        div_signed;
    logic        div_busy;
    logic        div_done;
    logic [31:0] quotient;
    logic [31:0] remainder;
    branch_upd_t br_upd;
    logic [31:0] link;
    logic        ale;

    regular_alu u_regular_alu (
        .op_i  (ex_i.aluop),
        .a_i   (ex_i.src1),
        .b_i   (ex_i.src2),
        .pc_i  (ex_i.pc),
        .res_o (alu_res)
    );

    assign is_div     = (ex_i.aluop == DIVW) || (ex_i.aluop == MODW) ||
                        (ex_i.aluop == DIVWU) || (ex_i.aluop == MODWU);
    assign is_quot    = (ex_i.aluop == DIVW) || (ex_i.aluop == DIVWU);
    assign div_signed = (ex_i.aluop == DIVW) || (ex_i.aluop == MODW);
    // done blocks a restart while the result is on ex_o
    assign div_start  = ex_i.valid && is_div && !div_busy && !div_done;

    div_alu u_div_alu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (div_start),
        .signed_i    (div_signed),
        .dividend_i  (ex_i.src1),
        .divisor_i   (ex_i.src2),
        .busy_o      (div_busy),
        .done_o      (div_done),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    branch_alu u_branch_alu (
        .op_i         (ex_i.aluop),
        .pc_i         (ex_i.pc),
        .inst_i       (ex_i.inst),
        .a_i          (ex_i.src1),
        .b_i          (ex_i.src2),
        .pre_taken_i  (ex_i.pre_taken),
        .pre_target_i (ex_i.pre_target),
        .upd_o        (br_upd),
        .link_o       (link)
    );

    lsu_agen #(
        .UNCACHE_HI (UNCACHE_HI)
    ) u_lsu_agen (
        .in_i  (ex_i),
        .req_o (dmem_o),
        .ale_o (ale)
    );

    always_comb begin
        bru_o           = br_upd;
        bru_o.is_branch = br_upd.is_branch && ex_i.valid;
        bru_o.flush     = br_upd.flush && ex_i.valid;
    end

    assign pause_o = div_start || div_busy || (dmem_o.valid && !addr_ok_i);

    always_comb begin
        ex_o.valid    = ex_i.valid && !pause_o;
        ex_o.pc       = ex_i.pc;
        ex_o.rd       = ex_i.rd;
        ex_o.rd_we    = ex_i.rd_we;
        ex_o.mem_addr = dmem_o.addr;
        ex_o.ale      = ale;
        case (ex_i.alusel)
            REGULAR: ex_o.wdata = alu_res;
            DIV:     ex_o.wdata = !div_done ? 32'b0 : (is_quot ? quotient : remainder);
            BRANCH:  ex_o.wdata = link;
            // load data is merged in the memory stage
            default: ex_o.wdata = 32'b0;
        endcase
    end

endmodule

// File: tb/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// expected write-back of a regular ALU operation
function automatic logic [31:0] expect_regular(alu_op_t op, logic [31:0] a, logic [31:0] b,
                                               logic [31:0] pc);
    logic [31:0] r;
    case (op)
        ADD:       r = a + b;
        SUB:       r = a - b;
        SLT:       r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        SLTU:      r = (a < b) ? 32'd1 : 32'd0;
        AND:       r = a & b;
        OR:        r = a | b;
        NOR:       r = ~(a | b);
        XOR:       r = a ^ b;
        SLL:       r = a << b[4:0];
        SRL:       r = a >> b[4:0];
        // logical shift with the vacated bits filled by the sign
        SRA:       r = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
        LU12I:     r = b;
        PCADDU12I: r = pc + b;
        default:   r = 32'd0;
    endcase
    return r;
endfunction

function automatic logic [31:0] expect_div(alu_op_t op, logic [31:0] a, logic [31:0] b);
    logic        quot;
    logic        sgn;
    logic [31:0] q;
    logic [31:0] r;
    quot = (op == DIVW) || (op == DIVWU);
    sgn  = (op == DIVW) || (op == MODW);
    if (b == 32'd0) begin
        q = 32'hffff_ffff;
        r = a;
    end else if (sgn && (a == 32'h8000_0000) && (b == 32'hffff_ffff)) begin
        q = 32'h8000_0000;
        r = 32'd0;
    end else if (sgn) begin
        q = $signed(a) / $signed(b);
        r = $signed(a) % $signed(b);
    end else begin
        q = a / b;
        r = a % b;
    end
    return quot ? q : r;
endfunction

function automatic branch_upd_t expect_branch(alu_op_t op, logic [31:0] pc, logic [31:0] inst,
                                              logic [31:0] a, logic [31:0] b, logic pre_taken,
                                              logic [31:0] pre_target, output logic [31:0] link);
    logic [31:0] off16;
    logic [31:0] off26;
    branch_upd_t u;
    off16       = {{14{inst[25]}}, inst[25:10], 2'b00};
    off26       = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    u.is_branch = 1'b1;
    u.taken     = 1'b1;
    u.target    = pc + off16;
    case (op)
        BEQ:     u.taken = (a == b);
        BNE:     u.taken = (a != b);
        BLT:     u.taken = ($signed(a) < $signed(b));
        BGE:     u.taken = ($signed(a) >= $signed(b));
        BLTU:    u.taken = (a < b);
        BGEU:    u.taken = (a >= b);
        B, BL:   u.target = pc + off26;
        JIRL:    u.target = a + off16;
        default: begin
            u.is_branch = 1'b0;
            u.taken     = 1'b0;
        end
    endcase
    u.flush = u.is_branch &&
              ((u.taken != pre_taken) || (u.taken && (u.target != pre_target)));
    link    = pc + 32'd4;
    return u;
endfunction

// request expected on the cache port, lanes filled from the lowest enabled byte up
function automatic dmem_req_t expect_mem(ex_in_t ins, output logic ale);
    logic [31:0] off;
    logic [1:0]  lo;
    logic        is_store;
    int          base;
    int          k;
    dmem_req_t   q;
    q        = '0;
    ale      = 1'b0;
    base     = 0;
    is_store = (ins.aluop == STB) || (ins.aluop == STH) || (ins.aluop == STW);
    off      = is_store ? {{20{ins.inst[21]}}, ins.inst[21:10]} : ins.src2;
    q.addr   = ins.src1 + off;
    lo       = q.addr[1:0];
    q.we     = is_store;
    q.wstrb  = 4'hf;
    case (ins.aluop)
        LDH, LDHU: ale = lo[0];
        LDW:       ale = (lo != 2'b00);
        STB: begin
            q.wstrb = 4'b0001 << lo;
            base    = int'(lo);
        end
        STH: begin
            ale     = lo[0];
            q.wstrb = lo[1] ? 4'b1100 : 4'b0011;
            base    = lo[1] ? 2 : 0;
        end
        STW:       ale = (lo != 2'b00);
        default:   ale = 1'b0;
    endcase
    for (k = 0; k < 4; k++) begin
        if (is_store && q.wstrb[k]) begin
            q.wdata[8*k +: 8] = ins.src2[8*(k-base) +: 8];
        end
    end
    q.valid    = !ale;
    q.uncached = q.valid && (q.addr[31:16] == 16'hbfaf);
    return q;
endfunction

`endif

// File: tb/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;
    import ex_pkg::*;
    `include "ex_ref_model.svh"

    logic        clk;
    logic        rst_n_i;
    ex_in_t      ex_i;
    logic        addr_ok_i;
    ex_out_t     ex_o;
    dmem_req_t   dmem_o;
    branch_upd_t bru_o;
    logic        pause_o;

    int n_checks;
    int n_errors;
    bit timed_out;
    int wait_left;
    int min_wait;
    int cache_wait;

    alu_op_t reg_ops[13] = '{ADD, SUB, SLT, SLTU, AND, OR, NOR, XOR, SLL, SRL, SRA, LU12I,
                             PCADDU12I};
    alu_op_t div_ops[4]  = '{DIVW, MODW, DIVWU, MODWU};
    alu_op_t br_ops[9]   = '{BEQ, BNE, BLT, BGE, BLTU, BGEU, B, BL, JIRL};
    alu_op_t mem_ops[8]  = '{LDB, LDBU, LDH, LDHU, LDW, STB, STH, STW};

    ex_stage u_ex_stage (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .ex_i      (ex_i),
        .addr_ok_i (addr_ok_i),
        .ex_o      (ex_o),
        .dmem_o    (dmem_o),
        .bru_o     (bru_o),
        .pause_o   (pause_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        n_checks++;
        assert (cond === 1'b1) else begin
            $display("t=%0t: %s", $time, what);
            n_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s: %0d errors", name, n_errors - errs_before);
    endtask

    function automatic alu_sel_t unit_for(alu_op_t op);
        case (op)
            DIVW, MODW, DIVWU, MODWU:                   return DIV;
            BEQ, BNE, BLT, BGE, BLTU, BGEU, B, BL, JIRL: return BRANCH;
            LDB, LDBU, LDH, LDHU, LDW, STB, STH, STW:   return MEM;
            NOP:                                        return NONE;
            default:                                    return REGULAR;
        endcase
    endfunction

    function automatic ex_in_t random_instr(alu_op_t op);
        ex_in_t      ins;
        logic [31:0] r;
        ins.valid      = 1'b1;
        r              = $urandom();
        ins.pc         = {r[31:2], 2'b00};
        ins.inst       = $urandom();
        ins.aluop      = op;
        ins.alusel     = unit_for(op);
        ins.src1       = $urandom();
        ins.src2       = $urandom();
        r              = $urandom();
        ins.pre_taken  = r[0];
        ins.rd         = r[12:8];
        ins.rd_we      = r[13];
        r              = $urandom();
        ins.pre_target = {r[31:2], 2'b00};
        return ins;
    endfunction

    // bend src1 so the access lands on the wanted low address bits
    function automatic ex_in_t place_low_bits(ex_in_t ins, logic [1:0] lo);
        logic [31:0] off;
        if ((ins.aluop == STB) || (ins.aluop == STH) || (ins.aluop == STW)) begin
            off = {{20{ins.inst[21]}}, ins.inst[21:10]};
        end else begin
            off = ins.src2;
        end
        ins.src1[1:0] = lo - off[1:0];
        return ins;
    endfunction

    // present one instruction and hold it until the stage lets it go
    task automatic issue(input ex_in_t ins, input int limit, output int pause_cycles,
                         output int stall_cycles);
        int        cycles;
        bit        finished;
        dmem_req_t held;
        cycles       = 0;
        finished     = 0;
        pause_cycles = 0;
        @(posedge clk);
        #1;
        ex_i       = ins;
        wait_left  = $urandom_range(5, min_wait);
        cache_wait = wait_left;
        addr_ok_i  = (wait_left == 0);
        @(negedge clk);
        held = dmem_o;
        while (!finished && !timed_out) begin
            if (pause_o) begin
                pause_cycles++;
            end
            if (dmem_o.valid && !addr_ok_i) begin
                check_true(pause_o, "pause_o low while the cache holds back a request");
                check_true(dmem_o == held, "dmem_o changed while the cache held it back");
            end
            if (!pause_o && ex_o.valid) begin
                finished = 1;
            end else if (cycles == limit) begin
                timed_out = 1;
                $display("timeout: %s got no result after %0d cycles", ins.aluop.name(), limit);
            end else begin
                cycles++;
                @(posedge clk);
                #1;
                if (wait_left > 0) begin
                    wait_left--;
                end
                addr_ok_i = (wait_left == 0);
                @(negedge clk);
            end
        end
        if (finished) begin
            check_value("ex_o.pc", ex_o.pc, ins.pc);
            check_value("ex_o.rd", 32'(ex_o.rd), 32'(ins.rd));
            check_value("ex_o.rd_we", 32'(ex_o.rd_we), 32'(ins.rd_we));
        end
        stall_cycles = cycles;
    endtask

    task automatic check_mem(input ex_in_t ins, input int pause_cycles, input int stall_cycles);
        dmem_req_t exp;
        logic      ale;
        exp = expect_mem(ins, ale);
        check_value("ex_o.ale", 32'(ex_o.ale), 32'(ale));
        check_value("ex_o.mem_addr", ex_o.mem_addr, exp.addr);
        check_value("ex_o.wdata", ex_o.wdata, 32'd0);
        check_value("dmem_o.valid", 32'(dmem_o.valid), 32'(exp.valid));
        if (ale) begin
            check_true(pause_cycles == 0 && stall_cycles == 0, "misaligned access stalled");
        end else begin
            check_value("dmem_o.addr", dmem_o.addr, exp.addr);
            check_value("dmem_o.we", 32'(dmem_o.we), 32'(exp.we));
            check_value("dmem_o.wstrb", 32'(dmem_o.wstrb), 32'(exp.wstrb));
            check_value("dmem_o.uncached", 32'(dmem_o.uncached), 32'(exp.uncached));
            if (exp.we) begin
                check_value("dmem_o.wdata", dmem_o.wdata, exp.wdata);
            end
            check_value("pause cycles", pause_cycles, cache_wait);
            check_value("stall cycles", stall_cycles, cache_wait);
        end
    endtask

    task automatic test_idle();
        int          i;
        int          errs0;
        logic [31:0] r;
        ex_in_t      ins;
        errs0 = n_errors;
        for (i = 0; i < 40; i++) begin
            r = $urandom();
            case (r[1:0])
                2'd2:    ins = random_instr(reg_ops[$urandom_range(12, 0)]);
                2'd3:    ins = random_instr(br_ops[$urandom_range(8, 0)]);
                default: ins = random_instr(NOP);
            endcase
            ins.valid = r[2] | r[1];
            @(posedge clk);
            #1;
            ex_i      = ins;
            addr_ok_i = r[3];
            @(negedge clk);
            check_true(!pause_o, "pause_o raised by an idle or non-memory instruction");
            check_true(!dmem_o.valid, "dmem_o.valid raised without a memory instruction");
            check_value("ex_o.valid", 32'(ex_o.valid), 32'(ins.valid));
        end
        report_test("6 reset and idle", errs0);
    endtask

    task automatic test_regular();
        int     o;
        int     i;
        int     errs0;
        int     pc;
        int     sc;
        ex_in_t ins;
        errs0 = n_errors;
        for (o = 0; o < 13 && !timed_out; o++) begin
            for (i = 0; i < 8 && !timed_out; i++) begin
                ins = random_instr(reg_ops[o]);
                // equal operands for the compares
                if (i == 0) begin
                    ins.src2 = ins.src1;
                end
                issue(ins, 4, pc, sc);
                if (!timed_out) begin
                    check_true(pc == 0 && sc == 0, "regular operation did not finish at once");
                    check_value("ex_o.wdata", ex_o.wdata,
                                expect_regular(ins.aluop, ins.src1, ins.src2, ins.pc));
                end
            end
        end
        report_test("1 regular operations", errs0);
    endtask

    task automatic test_divide();
        int     i;
        int     errs0;
        int     pc;
        int     sc;
        ex_in_t ins;
        errs0 = n_errors;
        for (i = 0; i < 32 && !timed_out; i++) begin
            ins = random_instr(div_ops[i % 4]);
            case (i / 4)
                0: ins.src2 = 32'd0;
                1: begin
                    ins.src1 = 32'h8000_0000;
                    ins.src2 = 32'hffff_ffff;
                end
                2: ins.src2 = $urandom_range(15, 1);
                3: ins.src2 = -$urandom_range(15, 1);
                default: ins.src2 = ins.src2;
            endcase
            issue(ins, 40, pc, sc);
            if (!timed_out) begin
                check_value("pause cycles", pc, 33);
                check_value("stall cycles", sc, 33);
                check_value("ex_o.wdata", ex_o.wdata, expect_div(ins.aluop, ins.src1, ins.src2));
            end
        end
        report_test("2 division", errs0);
    endtask

    task automatic test_branch();
        int          o;
        int          i;
        int          errs0;
        int          pc;
        int          sc;
        ex_in_t      ins;
        branch_upd_t exp;
        logic [31:0] link;
        errs0 = n_errors;
        for (o = 0; o < 9 && !timed_out; o++) begin
            for (i = 0; i < 10 && !timed_out; i++) begin
                ins = random_instr(br_ops[o]);
                if (i < 3) begin
                    ins.src2 = ins.src1;
                end
                exp = expect_branch(ins.aluop, ins.pc, ins.inst, ins.src1, ins.src2,
                                    ins.pre_taken, ins.pre_target, link);
                // half of the predictions carry the right target
                if (i % 2 == 0) begin
                    ins.pre_target = exp.target;
                    exp = expect_branch(ins.aluop, ins.pc, ins.inst, ins.src1, ins.src2,
                                        ins.pre_taken, ins.pre_target, link);
                end
                issue(ins, 4, pc, sc);
                if (!timed_out) begin
                    check_true(pc == 0 && sc == 0, "branch stalled the stage");
                    check_value("bru_o.is_branch", 32'(bru_o.is_branch), 32'(exp.is_branch));
                    check_value("bru_o.taken", 32'(bru_o.taken), 32'(exp.taken));
                    check_value("bru_o.target", bru_o.target, exp.target);
                    check_value("bru_o.flush", 32'(bru_o.flush), 32'(exp.flush));
                    check_value("ex_o.wdata", ex_o.wdata, link);
                end
            end
        end
        report_test("3 branches", errs0);
    endtask

    task automatic test_memory();
        int     o;
        int     i;
        int     errs0;
        int     pc;
        int     sc;
        ex_in_t ins;
        errs0 = n_errors;
        for (o = 0; o < 8 && !timed_out; o++) begin
            for (i = 0; i < 12 && !timed_out; i++) begin
                ins = place_low_bits(random_instr(mem_ops[o]), 2'(i % 4));
                issue(ins, 12, pc, sc);
                if (!timed_out) begin
                    check_mem(ins, pc, sc);
                end
            end
        end
        report_test("4 stores and loads", errs0);
    endtask

    task automatic test_window();
        int     i;
        int     errs0;
        int     pc;
        int     sc;
        ex_in_t ins;
        errs0    = n_errors;
        min_wait = 1;
        for (i = 0; i < 24 && !timed_out; i++) begin
            ins = random_instr(mem_ops[$urandom_range(7, 0)]);
            if (i % 2 == 0) begin
                // base well inside the window so any offset stays there
                ins.src1[31:14] = {16'hbfaf, 2'b01};
                ins.src2[31:11] = 21'd0;
            end else if (ins.src1[31:16] == 16'hbfaf) begin
                ins.src1[31:16] = 16'h1c00;
            end
            ins = place_low_bits(ins, 2'b00);
            issue(ins, 12, pc, sc);
            if (!timed_out) begin
                check_mem(ins, pc, sc);
                check_true(sc >= 1, "request accepted without back-pressure");
                if (i % 2 == 0) begin
                    check_true(dmem_o.uncached, "access in the uncached window not marked");
                end
            end
        end
        min_wait = 0;
        report_test("5 back-pressure and uncached window", errs0);
    endtask

    initial begin
        void'($urandom(32'h8d41_7207));
        n_checks     = 0;
        n_errors     = 0;
        timed_out    = 0;
        wait_left    = 0;
        min_wait     = 0;
        cache_wait   = 0;
        rst_n_i      = 1'b0;
        addr_ok_i    = 1'b1;
        ex_i         = '0;
        ex_i.aluop   = NOP;
        ex_i.alusel  = NONE;
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        test_idle();
        test_regular();
        test_divide();
        test_branch();
        test_memory();
        test_window();
        $display("checks %0d, errors %0d, timeout %0d", n_checks, n_errors, timed_out);
        if (n_errors == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+tb
common/ex_pkg.sv
design/regular_alu.sv
divider/div_alu.sv
design/branch_alu.sv
design/lsu_agen.sv
design/ex_stage.sv
tb/tb_ex_stage.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ex_stage -f verilog.f \
    -o tb_ex_stage > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_ex_stage > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
